// File: common/cu_types_pkg.sv
// Compute-unit side types for edge items, configuration and the job base address
package cu_types_pkg;

	`include "edge_write_defs.svh"

	//////////////////////////////////////////////////////////////////////
	// Plain vectors
	//////////////////////////////////////////////////////////////////////

	typedef logic [`EDGE_INDEX_BITS-1:0] edge_index_t;
	typedef logic [`EDGE_DATA_BITS-1:0]  edge_data_t;
	typedef logic [`MEM_ADDR_BITS-1:0]   mem_base_t;
	typedef logic [`CONFIG_BITS-1:0]     cu_config_t;

	//////////////////////////////////////////////////////////////////////
	// Configuration word layout
	//////////////////////////////////////////////////////////////////////

	// Abort code, see map_abort_mode in mem_bus_pkg
	localparam int CFG_ABORT_LSB = 0;
	localparam int CFG_ABORT_MSB = 2;

	// Set for ordered writes, clear for non-allocating writes
	localparam int CFG_ORDERED_BIT = 4;

	//////////////////////////////////////////////////////////////////////
	// Edge result
	//////////////////////////////////////////////////////////////////////

	// One result from the graph walk
	typedef struct packed {
		logic        valid;
		edge_index_t index;
		edge_data_t  data;
	} edge_write_t;

endpackage

// File: common/edge_write_defs.svh
// Width and size macros for the edge write path, included by the packages and the testbench
`ifndef EDGE_WRITE_DEFS_SVH
`define EDGE_WRITE_DEFS_SVH

// Edge result fields
`define EDGE_INDEX_BITS 32
`define EDGE_DATA_BITS 32

// Bytes per edge value written to memory
`define DATA_SIZE_WRITE 4

// One bus word is one cacheline
`define CACHELINE_BYTES 16

// Byte address width on the memory side
`define MEM_ADDR_BITS 32

// Configuration word of the compute unit
`define CONFIG_BITS 32

// Default depth of the write command FIFO
`define CMD_BUFFER_DEPTH 8

`endif

// File: common/mem_bus_pkg.sv
// Memory side types for write commands, cacheline data, byte selects and cycle tags
package mem_bus_pkg;

	`include "edge_write_defs.svh"

	// Derived sizes
	localparam int WORD_BITS       = `DATA_SIZE_WRITE * 8;
	localparam int DATA_LANES      = `CACHELINE_BYTES / `DATA_SIZE_WRITE;
	localparam int LANE_BITS       = $clog2(DATA_LANES);
	localparam int SIZE_SHIFT      = $clog2(`DATA_SIZE_WRITE);
	localparam int OFFSET_BITS     = $clog2(`CACHELINE_BYTES);
	localparam int ABORT_CODE_BITS = 3;

	typedef logic [`MEM_ADDR_BITS-1:0]     mem_addr_t;
	typedef logic [`CACHELINE_BYTES*8-1:0] cacheline_t;
	typedef logic [`CACHELINE_BYTES-1:0]   byte_sel_t;

	typedef enum logic [2:0] {
		abt_strict     = 3'd0,
		abt_abort      = 3'd1,
		abt_page_fault = 3'd2,
		abt_spec       = 3'd3,
		abt_partial    = 3'd4
	} abort_mode_t;

	typedef enum logic {
		write_na = 1'b0,
		write_ms = 1'b1
	} write_kind_t;

	// Carried on wb_tgc
	typedef struct packed {
		write_kind_t kind;
		abort_mode_t abort_mode;
	} write_tag_t;

	typedef struct packed {
		mem_addr_t  addr;
		cacheline_t data;
		byte_sel_t  sel;
		write_tag_t tag;
	} write_cmd_t;

	// Unknown codes fall back to strict
	function automatic abort_mode_t map_abort_mode(input logic [ABORT_CODE_BITS-1:0] code);
		abort_mode_t mode;
		case (code)
			3'd1:    mode = abt_abort;
			3'd2:    mode = abt_page_fault;
			3'd3:    mode = abt_spec;
			3'd4:    mode = abt_partial;
			default: mode = abt_strict;
		endcase
		return mode;
	endfunction

	// Memory is big endian, edge values arrive little endian
	function automatic logic [WORD_BITS-1:0] swap_bytes(input logic [WORD_BITS-1:0] value);
		logic [WORD_BITS-1:0] swapped;
		for (int i = 0; i < `DATA_SIZE_WRITE; i++) begin
			swapped[i*8 +: 8] = value[(`DATA_SIZE_WRITE-1-i)*8 +: 8];
		end
		return swapped;
	endfunction

endpackage

// File: edge_write/edge_write_command_gen.sv
// Two-stage generator that turns one edge result into one cacheline write command
`timescale 1ns/1ns

module edge_write_command_gen
	import cu_types_pkg::*;
	import mem_bus_pkg::*;
(
	input  logic        clock,
	input  logic        rstn,
	input  edge_write_t item,
	input  mem_base_t   base,
	input  cu_config_t  config_word,
	output write_cmd_t  cmd,
	output logic        push
);

	// Stage one, latched item
	logic                 item_valid_q;
	edge_index_t          item_index_q;
	edge_data_t           item_data_q;

	// Stage two inputs
	logic [LANE_BITS-1:0] lane;
	mem_addr_t            byte_addr;
	write_cmd_t           cmd_next;

	//////////////////////////////////////////////////////////////////////
	// Input latch
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			item_valid_q <= 1'b0;
		end else begin
			item_valid_q <= item.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (item.valid) begin
			item_index_q <= item.index;
			item_data_q  <= item.data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Command build
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// Lane inside the cacheline picked by the low index bits
		lane      = item_index_q[LANE_BITS-1:0];
		byte_addr = base + (mem_addr_t'(item_index_q) << SIZE_SHIFT);

		cmd_next.addr                   = byte_addr;
		cmd_next.addr[OFFSET_BITS-1:0]  = '0;
		cmd_next.sel  = byte_sel_t'({`DATA_SIZE_WRITE{1'b1}}) << (lane * `DATA_SIZE_WRITE);
		cmd_next.data = cacheline_t'(swap_bytes(item_data_q)) << (lane * WORD_BITS);

		cmd_next.tag.kind       = config_word[CFG_ORDERED_BIT] ? write_ms : write_na;
		cmd_next.tag.abort_mode = map_abort_mode(config_word[CFG_ABORT_MSB:CFG_ABORT_LSB]);
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			push <= 1'b0;
		end else begin
			push <= item_valid_q;
		end
	end

	always_ff @(posedge clock) begin
		if (item_valid_q) begin
			cmd <= cmd_next;
		end
	end

endmodule

// File: edge_write/write_command_buffer.sv
// Circular FIFO of write commands that reports its free space to the control module
`timescale 1ns/1ns

module write_command_buffer
	import mem_bus_pkg::*;
#(
	parameter  int DEPTH      = 8,
	localparam int PTR_BITS   = $clog2(DEPTH),
	localparam int COUNT_BITS = $clog2(DEPTH + 1)
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  push,
	input  logic                  pop,
	input  write_cmd_t            push_cmd,
	output write_cmd_t            pop_cmd,
	output logic                  empty,
	output logic [COUNT_BITS-1:0] free_count
);

	localparam logic [PTR_BITS-1:0]   LAST_PTR = PTR_BITS'(DEPTH - 1);
	localparam logic [COUNT_BITS-1:0] FULL     = COUNT_BITS'(DEPTH);

	write_cmd_t            mem [DEPTH];
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [COUNT_BITS-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	// Pushes into a full FIFO and pops from an empty one are dropped
	assign do_push = push && (count != FULL);
	assign do_pop  = pop && (count != '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push_cmd;
		end
	end

	// Head of the queue is visible before it is popped
	assign pop_cmd    = mem[rd_ptr];
	assign empty      = (count == '0);
	assign free_count = FULL - count;

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the edge write testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module cu_edge_write_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vcu_edge_write_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
	exit 0
fi

echo "Simulation did not report a pass"
exit 1

// File: sim.f
+incdir+common
common/cu_types_pkg.sv
common/mem_bus_pkg.sv
edge_write/edge_write_command_gen.sv
edge_write/write_command_buffer.sv
source/cu_write_control.sv
source/wb_write_master.sv
source/cu_edge_write_top.sv
verification/cu_edge_write_asserts.sv
verification/cu_edge_write_tb.sv

// File: source/cu_edge_write_top.sv
// Top level of the edge write path, connecting control, generator, FIFO and bus master
`timescale 1ns/1ns
`include "edge_write_defs.svh"

module cu_edge_write_top
	import cu_types_pkg::*;
	import mem_bus_pkg::*;
#(
	parameter  int DEPTH      = `CMD_BUFFER_DEPTH,
	localparam int COUNT_BITS = $clog2(DEPTH + 1)
) (
	input  logic        clock,
	input  logic        rstn,
	input  logic        enable,
	input  cu_config_t  config_in,
	input  mem_base_t   base_in,
	input  edge_write_t edge_in,
	output logic        edge_ready,
	output logic        wb_cyc,
	output logic        wb_stb,
	output logic        wb_we,
	output mem_addr_t   wb_adr,
	output cacheline_t  wb_dat_w,
	output byte_sel_t   wb_sel,
	output write_tag_t  wb_tgc,
	input  logic        wb_ack
);

	edge_write_t           gen_item;
	cu_config_t            config_word;
	mem_base_t             base;
	write_cmd_t            gen_cmd;
	logic                  gen_push;
	write_cmd_t            buf_cmd;
	logic                  buf_empty;
	logic [COUNT_BITS-1:0] buf_free;
	logic                  pop;
	logic                  start;
	logic                  done;

	cu_write_control #(
		.DEPTH (DEPTH)
	) i_control (
		.clock       (clock),
		.rstn        (rstn),
		.enable      (enable),
		.config_in   (config_in),
		.base_in     (base_in),
		.edge_in     (edge_in),
		.edge_ready  (edge_ready),
		.gen_item    (gen_item),
		.config_word (config_word),
		.base        (base),
		.buf_empty   (buf_empty),
		.buf_free    (buf_free),
		.pop         (pop),
		.start       (start),
		.done        (done)
	);

	edge_write_command_gen i_gen (
		.clock       (clock),
		.rstn        (rstn),
		.item        (gen_item),
		.base        (base),
		.config_word (config_word),
		.cmd         (gen_cmd),
		.push        (gen_push)
	);

	write_command_buffer #(
		.DEPTH (DEPTH)
	) i_buffer (
		.clock      (clock),
		.rstn       (rstn),
		.push       (gen_push),
		.pop        (pop),
		.push_cmd   (gen_cmd),
		.pop_cmd    (buf_cmd),
		.empty      (buf_empty),
		.free_count (buf_free)
	);

	wb_write_master i_master (
		.clock    (clock),
		.rstn     (rstn),
		.start    (start),
		.cmd      (buf_cmd),
		.done     (done),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_sel   (wb_sel),
		.wb_tgc   (wb_tgc),
		.wb_ack   (wb_ack)
	);

endmodule

// File: source/cu_write_control.sv
// Control for the edge write path: enable, configuration, intake gating and bus sequencing
`timescale 1ns/1ns

module cu_write_control
	import cu_types_pkg::*;
#(
	parameter  int DEPTH      = 8,
	localparam int COUNT_BITS = $clog2(DEPTH + 1)
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enable,
	input  cu_config_t            config_in,
	input  mem_base_t             base_in,
	input  edge_write_t           edge_in,
	output logic                  edge_ready,
	output edge_write_t           gen_item,
	output cu_config_t            config_word,
	output mem_base_t             base,
	input  logic                  buf_empty,
	input  logic [COUNT_BITS-1:0] buf_free,
	output logic                  pop,
	output logic                  start,
	input  logic                  done
);

	// New item plus the two still in the generator
	localparam logic [COUNT_BITS-1:0] READY_FREE = COUNT_BITS'(3);

	typedef enum logic [1:0] {
		st_idle,
		st_issue,
		st_wait
	} state_t;

	state_t state;
	state_t state_next;
	logic   enabled;

	//////////////////////////////////////////////////////////////////////
	// Enable and configuration
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled     <= 1'b0;
			config_word <= '0;
			base        <= '0;
		end else begin
			enabled <= enable;
			if (enabled) begin
				// All-zero word keeps the previous settings
				if (|config_in) begin
					config_word <= config_in;
				end
				base <= base_in;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Intake
	//////////////////////////////////////////////////////////////////////

	assign edge_ready = enabled && (buf_free >= READY_FREE);

	always_comb begin
		gen_item       = edge_in;
		gen_item.valid = edge_in.valid && edge_ready;
	end

	//////////////////////////////////////////////////////////////////////
	// Bus sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (!buf_empty) begin
					state_next = st_issue;
				end
			end
			st_issue: state_next = st_wait;
			st_wait: begin
				if (done) begin
					state_next = st_idle;
				end
			end
			default: state_next = st_idle;
		endcase
	end

	// Master takes the head entry on the same edge that pops it
	assign pop   = (state == st_issue);
	assign start = (state == st_issue);

endmodule

// File: source/wb_write_master.sv
// Wishbone classic master that performs one single write per start pulse
`timescale 1ns/1ns

module wb_write_master
	import mem_bus_pkg::*;
(
	input  logic       clock,
	input  logic       rstn,
	input  logic       start,
	input  write_cmd_t cmd,
	output logic       done,
	output logic       wb_cyc,
	output logic       wb_stb,
	output logic       wb_we,
	output mem_addr_t  wb_adr,
	output cacheline_t wb_dat_w,
	output byte_sel_t  wb_sel,
	output write_tag_t wb_tgc,
	input  logic       wb_ack
);

	logic active;

	// Bus cycle state
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active <= 1'b0;
		end else if (active && wb_ack) begin
			active <= 1'b0;
		end else if (start) begin
			active <= 1'b1;
		end
	end

	// Command held for the whole cycle
	always_ff @(posedge clock) begin
		if (start && !active) begin
			wb_adr   <= cmd.addr;
			wb_dat_w <= cmd.data;
			wb_sel   <= cmd.sel;
			wb_tgc   <= cmd.tag;
		end
	end

	// Writes only, so all three strobes move together
	assign wb_cyc = active;
	assign wb_stb = active;
	assign wb_we  = active;

	assign done = active && wb_ack;

endmodule

// File: verification/cu_edge_write_asserts.sv
// Wishbone protocol checks for the write master, bound into every wb_write_master instance
`timescale 1ns/1ns

module cu_edge_write_asserts
	import mem_bus_pkg::*;
(
	input logic       clock,
	input logic       rstn,
	input logic       wb_cyc,
	input logic       wb_stb,
	input mem_addr_t  wb_adr,
	input cacheline_t wb_dat_w,
	input byte_sel_t  wb_sel,
	input write_tag_t wb_tgc,
	input logic       wb_ack
);

	// Strobe only inside a cycle
	stb_in_cycle: assert property (@(posedge clock) disable iff (!rstn) wb_stb |-> wb_cyc)
		else $error("wb_stb high outside a bus cycle");

	// Held command until the slave acks
	cmd_stable: assert property (@(posedge clock) disable iff (!rstn)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat_w)
			&& $stable(wb_sel) && $stable(wb_tgc))
		else $error("Write command changed or strobe dropped before ack");

	stb_after_ack: assert property (@(posedge clock) disable iff (!rstn)
		wb_stb && wb_ack |=> !wb_stb)
		else $error("wb_stb still high after ack");

endmodule

bind wb_write_master cu_edge_write_asserts i_asserts (
	.clock    (clock),
	.rstn     (rstn),
	.wb_cyc   (wb_cyc),
	.wb_stb   (wb_stb),
	.wb_adr   (wb_adr),
	.wb_dat_w (wb_dat_w),
	.wb_sel   (wb_sel),
	.wb_tgc   (wb_tgc),
	.wb_ack   (wb_ack)
);

// File: verification/cu_edge_write_tb.sv
// Testbench for the edge write path; drives edge items, models a Wishbone slave, checks every write
`timescale 1ns/1ns
`include "edge_write_defs.svh"

module cu_edge_write_tb
	import cu_types_pkg::*;
	import mem_bus_pkg::*;
();

	localparam int PERIOD_NS          = 100;
	localparam int TOTAL_ITEMS        = 1 + 8 + 8 + (2 * `CMD_BUFFER_DEPTH + 4) + 4;
	localparam int WORST_WRITE_CYCLES = 24;
	localparam int OVERHEAD_CYCLES    = 400;
	localparam int WATCHDOG_NS        =
		(TOTAL_ITEMS * WORST_WRITE_CYCLES + OVERHEAD_CYCLES) * PERIOD_NS;
	localparam int READY_LIMIT        = 200;
	localparam int DRAIN_LIMIT        = 1000;
	localparam logic [31:0] SEED      = 32'h8a3b_c0da;

	logic        clock;
	logic        rstn;
	logic        enable;
	cu_config_t  config_in;
	mem_base_t   base_in;
	edge_write_t edge_in;
	logic        edge_ready;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	mem_addr_t   wb_adr;
	cacheline_t  wb_dat_w;
	byte_sel_t   wb_sel;
	write_tag_t  wb_tgc;
	logic        wb_ack;

	// Settings the DUT should be using, tracked from what was driven
	cu_config_t  cur_config;
	mem_base_t   cur_base;
	write_cmd_t  exp_q[$];
	write_cmd_t  obs_q[$];
	logic [31:0] data_rng;
	logic [31:0] ack_rng;
	logic        slow_acks;
	logic        saw_not_ready;
	int          writes_seen;
	int          error_count;
	int          check_count;
	int          tests_run;
	int          tests_bad;
	int          test_errors_start;

	cu_edge_write_top i_dut (
		.clock      (clock),
		.rstn       (rstn),
		.enable     (enable),
		.config_in  (config_in),
		.base_in    (base_in),
		.edge_in    (edge_in),
		.edge_ready (edge_ready),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_sel     (wb_sel),
		.wb_tgc     (wb_tgc),
		.wb_ack     (wb_ack)
	);

	always #(PERIOD_NS / 2) clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// Reference model and helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic write_cmd_t expected_write(input edge_index_t index, input edge_data_t data,
			input mem_base_t b, input cu_config_t cfg);
		write_cmd_t  want;
		logic [1:0]  lane;
		logic [31:0] swapped;
		lane    = index[1:0];
		swapped = {data[7:0], data[15:8], data[23:16], data[31:24]};
		// Four bytes per index, then down to the cacheline
		want.addr       = b + {index[29:0], 2'b00};
		want.addr[3:0]  = 4'h0;
		want.sel        = 16'h000f << (4 * lane);
		want.data       = {96'h0, swapped} << (32 * lane);
		want.tag.kind   = cfg[4] ? write_ms : write_na;
		case (cfg[2:0])
			3'd1:    want.tag.abort_mode = abt_abort;
			3'd2:    want.tag.abort_mode = abt_page_fault;
			3'd3:    want.tag.abort_mode = abt_spec;
			3'd4:    want.tag.abort_mode = abt_partial;
			default: want.tag.abort_mode = abt_strict;
		endcase
		return want;
	endfunction

	task automatic check_bit(input string name, input logic got, input logic want);
		check_count++;
		if (got !== want) begin
			$display("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, want);
			error_count++;
		end
	endtask

	task automatic check_addr(input mem_addr_t got, input mem_addr_t want);
		check_count++;
		if (got !== want) begin
			$display("FAILED at %0t ns: wb_adr is %h, expected %h", $time, got, want);
			error_count++;
		end
	endtask

	task automatic check_lane(input cacheline_t got, input cacheline_t want, input byte_sel_t sel);
		cacheline_t mask;
		for (int i = 0; i < `CACHELINE_BYTES; i++) begin
			mask[i*8 +: 8] = {8{sel[i]}};
		end
		check_count++;
		if ((got & mask) !== (want & mask)) begin
			$display("FAILED at %0t ns: wb_dat_w is %h, expected %h", $time, got & mask,
				want & mask);
			error_count++;
		end
	endtask

	task automatic check_sel(input byte_sel_t got, input byte_sel_t want);
		check_count++;
		if (got !== want) begin
			$display("FAILED at %0t ns: wb_sel is %h, expected %h", $time, got, want);
			error_count++;
		end
	endtask

	task automatic check_tag(input write_tag_t got, input write_tag_t want);
		check_count++;
		if (got !== want) begin
			$display("FAILED at %0t ns: wb_tgc is %h, expected %h", $time, got, want);
			error_count++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus tasks, all entered and left on a falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic apply_config(input cu_config_t cfg, input mem_base_t b);
		config_in = cfg;
		base_in   = b;
		if (cfg != '0) begin
			cur_config = cfg;
		end
		cur_base = b;
		// Registered enable, then the latch itself
		repeat (2) @(negedge clock);
	endtask

	task automatic send_item(input edge_index_t index, input edge_data_t data);
		int cycles;
		cycles        = 0;
		edge_in.valid = 1'b1;
		edge_in.index = index;
		edge_in.data  = data;
		while (!edge_ready && cycles < READY_LIMIT) begin
			saw_not_ready = 1'b1;
			@(negedge clock);
			cycles++;
		end
		if (edge_ready) begin
			exp_q.push_back(expected_write(index, data, cur_base, cur_config));
		end else begin
			$display("edge_ready stayed low for %0d cycles, item %0d was never taken",
				cycles, index);
			error_count++;
		end
		@(negedge clock);
		edge_in.valid = 1'b0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while ((exp_q.size() != 0 || obs_q.size() != 0 || wb_cyc) && cycles < DRAIN_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		if (cycles >= DRAIN_LIMIT) begin
			$display("Timed out at %0t ns with %0d writes still missing on the bus",
				$time, exp_q.size());
			error_count++;
			exp_q.delete();
		end
		repeat (2) @(negedge clock);
	endtask

	task automatic finish_test(input int number, input string name);
		int errs;
		errs = error_count - test_errors_start;
		tests_run++;
		if (errs != 0) begin
			tests_bad++;
		end
		$display("test %0d, %s: %0d errors", number, name, errs);
		test_errors_start = error_count;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Wishbone slave and compare process
	//////////////////////////////////////////////////////////////////////

	initial begin : slave_model
		int         delay;
		write_cmd_t seen;
		wb_ack = 1'b0;
		forever begin
			@(negedge clock);
			wb_ack = 1'b0;
			if (rstn && wb_cyc && wb_stb) begin
				ack_rng = xorshift(ack_rng);
				delay   = int'(ack_rng % 6);
				if (slow_acks) begin
					delay = delay + 10;
				end
				repeat (delay) @(negedge clock);
				wb_ack    = 1'b1;
				check_bit("wb_we", wb_we, 1'b1);
				seen.addr = wb_adr;
				seen.data = wb_dat_w;
				seen.sel  = wb_sel;
				seen.tag  = wb_tgc;
				obs_q.push_back(seen);
				writes_seen++;
			end
		end
	end

	initial begin : compare_writes
		write_cmd_t got;
		write_cmd_t want;
		forever begin
			@(posedge clock);
			while (obs_q.size() > 0) begin
				got = obs_q.pop_front();
				if (exp_q.size() == 0) begin
					$display("Write to address %h at %0t ns came with no item pending",
						got.addr, $time);
					error_count++;
				end else begin
					want = exp_q.pop_front();
					check_addr(got.addr, want.addr);
					check_sel(got.sel, want.sel);
					check_lane(got.data, want.data, want.sel);
					check_tag(got.tag, want.tag);
				end
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0t ns, the run did not finish", $time);
		$display("tests failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin : main
		cu_config_t configs[6];
		int         count;
		configs = '{32'h10, 32'h01, 32'h12, 32'h03, 32'h07, 32'h14};
		clock = 1'b0;
		rstn = 1'b0;
		enable = 1'b0;
		config_in = '0;
		base_in = '0;
		edge_in = '0;
		cur_config = '0;
		cur_base = '0;
		data_rng = SEED;
		ack_rng = SEED;
		slow_acks = 1'b0;
		saw_not_ready = 1'b0;
		writes_seen = 0;
		error_count = 0;
		check_count = 0;
		tests_run = 0;
		tests_bad = 0;
		test_errors_start = 0;

		repeat (8) begin
			@(negedge clock);
			check_bit("edge_ready", edge_ready, 1'b0);
			check_bit("wb_cyc", wb_cyc, 1'b0);
			check_bit("wb_stb", wb_stb, 1'b0);
		end
		rstn = 1'b1;
		@(negedge clock);
		check_bit("edge_ready", edge_ready, 1'b0);
		check_bit("wb_cyc", wb_cyc, 1'b0);
		check_bit("wb_stb", wb_stb, 1'b0);
		finish_test(6, "outputs low in reset");

		enable = 1'b1;
		apply_config(32'h11, 32'h4000_0000);
		send_item(5, 32'h1122_3344);
		wait_drain();
		finish_test(1, "single item");

		apply_config(32'h11, 32'h0001_2340);
		for (int i = 0; i < 8; i++) begin
			data_rng = xorshift(data_rng);
			send_item(i, data_rng);
		end
		wait_drain();
		finish_test(2, "lanes and alignment");

		for (int k = 0; k < 6; k++) begin
			apply_config(configs[k], 32'h4000_1000);
			data_rng = xorshift(data_rng);
			send_item(16 + k, data_rng);
			wait_drain();
		end
		// Zero word must leave ordered partial writes in force
		apply_config(32'h0, 32'h4000_2000);
		send_item(40, 32'hdead_beef);
		send_item(41, 32'h0bad_f00d);
		wait_drain();
		finish_test(3, "abort modes and write kinds");

		apply_config(32'h13, 32'h8000_0000);
		slow_acks     = 1'b1;
		saw_not_ready = 1'b0;
		for (int i = 0; i < 2 * `CMD_BUFFER_DEPTH + 4; i++) begin
			data_rng = xorshift(data_rng);
			send_item(3 * i, data_rng);
		end
		wait_drain();
		slow_acks = 1'b0;
		if (!saw_not_ready) begin
			$display("edge_ready never dropped while the FIFO was filling");
			error_count++;
		end
		finish_test(4, "back-pressure under slow acks");

		for (int i = 0; i < 4; i++) begin
			data_rng = xorshift(data_rng);
			send_item(100 + i, data_rng);
		end
		enable = 1'b0;
		@(negedge clock);
		edge_in.valid = 1'b1;
		edge_in.index = 200;
		edge_in.data  = 32'h5555_aaaa;
		repeat (30) begin
			check_bit("edge_ready", edge_ready, 1'b0);
			@(negedge clock);
		end
		edge_in.valid = 1'b0;
		wait_drain();
		count = writes_seen;
		repeat (20) @(negedge clock);
		if (writes_seen != count) begin
			$display("A bus cycle started with enable low after the FIFO drained");
			error_count++;
		end
		finish_test(5, "enable low");

		$display("%0d tests run, %0d with errors, %0d checks, %0d errors",
			tests_run, tests_bad, check_count, error_count);
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
